/* common/spi_pkg.sv */
/*
 * Shared definitions for the AXI4-Lite SPI master
 * Data, divider and bus typedefs
 * Register map, response codes and status bit positions
 * SPI engine state encoding
 */

package spi_pkg;

  // One SPI data byte
  typedef logic [7:0] spi_byte_t;
  // Sclk half period in clk cycles, zero behaves as one
  typedef logic [7:0] spi_div_t;

  typedef logic [3:0]  axil_addr_t;
  typedef logic [31:0] axil_data_t;
  typedef logic [1:0]  axil_resp_t;

  localparam axil_resp_t RESP_OKAY   = 2'b00;
  localparam axil_resp_t RESP_SLVERR = 2'b10;

  // Register byte offsets
  localparam axil_addr_t REG_CTRL_STATUS = 4'h0;
  localparam axil_addr_t REG_DIV         = 4'h4;
  localparam axil_addr_t REG_TXDATA      = 4'h8;
  localparam axil_addr_t REG_RXDATA      = 4'hC;

  // Status word bits
  localparam int STAT_BUSY_BIT = 0;
  localparam int STAT_DONE_BIT = 1;

  typedef enum logic [1:0] {
    SPI_IDLE,
    SPI_LEAD,
    SPI_SHIFT
  } spi_state_t;

endpackage

/* spi/spi_engine.sv */
/*
 * Mode-3 SPI shift engine, one byte per transfer, MSB first
 * Run-time half-period divider, single active-low chip select
 * Concurrent checks on idle clock level and done/busy exclusion
 */

`timescale 1ns/10ps

module spi_engine import spi_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      start,
  input  spi_byte_t tx_byte,
  input  spi_div_t  div,
  input  logic      miso,
  output logic      sclk,
  output logic      mosi,
  output logic      cs_n,
  output logic      busy,
  output logic      done,
  output spi_byte_t rx_byte
);

  spi_state_t state;
  spi_div_t   div_q;
  spi_div_t   cnt;
  logic [2:0] bit_cnt;
  spi_byte_t  tx_sr;
  spi_byte_t  rx_sr;

  logic half_end;
  logic sclk_fall;
  logic sclk_rise;
  logic last_end;

  // Counter reload for one half period, zero divider counts as one
  function automatic spi_div_t half_reload(spi_div_t d);
    return (d == '0) ? '0 : spi_div_t'(d - 8'd1);
  endfunction

  assign busy = (state != SPI_IDLE);

  assign half_end  = (cnt == '0);
  // Falling edges come from the lead-in and from every bit but the last
  assign sclk_fall = half_end && ((state == SPI_LEAD) ||
                     (state == SPI_SHIFT && sclk && bit_cnt != 3'd7));
  assign sclk_rise = half_end && (state == SPI_SHIFT) && !sclk;
  // End of the eighth high half period
  assign last_end  = half_end && (state == SPI_SHIFT) && sclk && (bit_cnt == 3'd7);

  // FSM, pin drivers and counters
  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= SPI_IDLE;
      sclk    <= 1'b1;
      cs_n    <= 1'b1;
      mosi    <= 1'b1;
      done    <= 1'b0;
      cnt     <= '0;
      bit_cnt <= '0;
    end else begin
      done <= 1'b0;
      case (state)
        SPI_IDLE: begin
          if (start) begin
            state   <= SPI_LEAD;
            cs_n    <= 1'b0;
            cnt     <= half_reload(div);
            bit_cnt <= '0;
          end
        end
        SPI_LEAD: begin
          if (sclk_fall) begin
            state <= SPI_SHIFT;
            sclk  <= 1'b0;
            mosi  <= tx_sr[7];
            cnt   <= half_reload(div_q);
          end else begin
            cnt <= cnt - 8'd1;
          end
        end
        SPI_SHIFT: begin
          if (!half_end) begin
            cnt <= cnt - 8'd1;
          end else if (sclk_rise) begin
            sclk <= 1'b1;
            cnt  <= half_reload(div_q);
          end else if (last_end) begin
            state <= SPI_IDLE;
            cs_n  <= 1'b1;
            done  <= 1'b1;
          end else begin
            sclk    <= 1'b0;
            mosi    <= tx_sr[7];
            bit_cnt <= bit_cnt + 3'd1;
            cnt     <= half_reload(div_q);
          end
        end
        default: state <= SPI_IDLE;
      endcase
    end
  end

  // Shift registers and latched settings
  always_ff @(posedge clk) begin
    if (state == SPI_IDLE && start) begin
      tx_sr <= tx_byte;
      div_q <= div;
    end else if (sclk_fall) begin
      tx_sr <= {tx_sr[6:0], 1'b0};
    end
    // Sample miso as sclk rises
    if (sclk_rise) begin
      rx_sr <= {rx_sr[6:0], miso};
    end
    if (last_end) begin
      rx_byte <= rx_sr;
    end
  end

  a_idle_sclk_high: assert property (@(posedge clk) disable iff (rst)
    (state == SPI_IDLE) |-> sclk);

  a_done_not_busy: assert property (@(posedge clk) disable iff (rst)
    !(done && busy));

endmodule

/* spi/spi_regs.sv */
/*
 * AXI4-Lite slave register block for the SPI engine
 * Control/status, divider, transmit and receive registers
 * Start pulse generation and sticky done flag
 * Response hold checks on both response channels
 */

`timescale 1ns/10ps

module spi_regs import spi_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  axil_addr_t awaddr,
  input  logic       awvalid,
  output logic       awready,
  input  axil_data_t wdata,
  input  logic [3:0] wstrb,
  input  logic       wvalid,
  output logic       wready,
  output axil_resp_t bresp,
  output logic       bvalid,
  input  logic       bready,
  input  axil_addr_t araddr,
  input  logic       arvalid,
  output logic       arready,
  output axil_data_t rdata,
  output axil_resp_t rresp,
  output logic       rvalid,
  input  logic       rready,
  input  logic       busy,
  input  logic       done,
  input  spi_byte_t  rx_byte,
  output logic       start,
  output spi_byte_t  tx_byte,
  output spi_div_t   div
);

  logic       wr_ready;
  logic       wr_hs;
  logic       rd_hs;
  logic       done_flag;
  axil_data_t rd_word;
  axil_resp_t rd_resp;

  function automatic logic is_mapped(axil_addr_t a);
    case (a)
      REG_CTRL_STATUS, REG_DIV, REG_TXDATA, REG_RXDATA: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  // Address and data are taken in the same cycle
  assign awready = wr_ready;
  assign wready  = wr_ready;
  assign wr_hs   = wr_ready && awvalid && wvalid;
  assign rd_hs   = arready && arvalid;

  // Write channel handshake
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ready <= 1'b0;
      bvalid   <= 1'b0;
    end else begin
      wr_ready <= awvalid && wvalid && !bvalid && !wr_ready;
      if (wr_hs) begin
        bvalid <= 1'b1;
      end else if (bready) begin
        bvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_hs) begin
      bresp <= is_mapped(awaddr) ? RESP_OKAY : RESP_SLVERR;
    end
  end

  // Configuration registers and start pulse
  always_ff @(posedge clk) begin
    if (rst) begin
      div   <= 8'd1;
      start <= 1'b0;
    end else begin
      start <= wr_hs && (awaddr == REG_CTRL_STATUS) && wdata[0] && !busy;
      if (wr_hs && awaddr == REG_DIV) begin
        div <= wdata[7:0];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_hs && awaddr == REG_TXDATA) begin
      tx_byte <= wdata[7:0];
    end
  end

  // A new completion wins over the clearing read of the sticky done flag
  always_ff @(posedge clk) begin
    if (rst) begin
      done_flag <= 1'b0;
    end else if (done) begin
      done_flag <= 1'b1;
    end else if (rd_hs && araddr == REG_RXDATA) begin
      done_flag <= 1'b0;
    end
  end

  always_comb begin
    rd_word = '0;
    rd_resp = RESP_OKAY;
    case (araddr)
      REG_CTRL_STATUS: begin
        rd_word[STAT_BUSY_BIT] = busy;
        rd_word[STAT_DONE_BIT] = done_flag;
      end
      REG_DIV:    rd_word[7:0] = div;
      REG_TXDATA: rd_word[7:0] = tx_byte;
      REG_RXDATA: rd_word[7:0] = rx_byte;
      default:    rd_resp = RESP_SLVERR;
    endcase
  end

  // Read channel handshake
  always_ff @(posedge clk) begin
    if (rst) begin
      arready <= 1'b0;
      rvalid  <= 1'b0;
    end else begin
      arready <= arvalid && !rvalid && !arready;
      if (rd_hs) begin
        rvalid <= 1'b1;
      end else if (rready) begin
        rvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rd_hs) begin
      rdata <= rd_word;
      rresp <= rd_resp;
    end
  end

  a_bvalid_hold: assert property (@(posedge clk) disable iff (rst)
    (bvalid && !bready) |=> (bvalid && $stable(bresp)));

  a_rvalid_hold: assert property (@(posedge clk) disable iff (rst)
    (rvalid && !rready) |=> (rvalid && $stable(rdata) && $stable(rresp)));

endmodule

/* verilog/spi_axil_top.sv */
/*
 * Top level of the AXI4-Lite SPI master
 * Register block and mode-3 SPI engine
 */

`timescale 1ns/10ps

module spi_axil_top import spi_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  axil_addr_t awaddr,
  input  logic       awvalid,
  output logic       awready,
  input  axil_data_t wdata,
  input  logic [3:0] wstrb,
  input  logic       wvalid,
  output logic       wready,
  output axil_resp_t bresp,
  output logic       bvalid,
  input  logic       bready,
  input  axil_addr_t araddr,
  input  logic       arvalid,
  output logic       arready,
  output axil_data_t rdata,
  output axil_resp_t rresp,
  output logic       rvalid,
  input  logic       rready,
  output logic       sclk,
  output logic       mosi,
  output logic       cs_n,
  input  logic       miso
);

  // Register block to engine
  logic      start;
  spi_byte_t tx_byte;
  spi_div_t  div;
  // Engine back to register block
  logic      busy;
  logic      done;
  spi_byte_t rx_byte;

  spi_regs u_regs (
    .clk    (clk),     .rst     (rst),
    .awaddr (awaddr),  .awvalid (awvalid), .awready (awready),
    .wdata  (wdata),   .wstrb   (wstrb),   .wvalid  (wvalid),  .wready (wready),
    .bresp  (bresp),   .bvalid  (bvalid),  .bready  (bready),
    .araddr (araddr),  .arvalid (arvalid), .arready (arready),
    .rdata  (rdata),   .rresp   (rresp),   .rvalid  (rvalid),  .rready (rready),
    .busy   (busy),    .done    (done),    .rx_byte (rx_byte),
    .start  (start),   .tx_byte (tx_byte), .div     (div)
  );

  spi_engine u_engine (
    .clk     (clk),     .rst  (rst),
    .start   (start),   .tx_byte (tx_byte), .div (div),
    .miso    (miso),
    .sclk    (sclk),    .mosi (mosi),       .cs_n (cs_n),
    .busy    (busy),    .done (done),       .rx_byte (rx_byte)
  );

endmodule

/* test/spi_slave_model.sv */
/*
 * Behavioral mode-3 SPI device for the testbench
 * Shifts out a preset reply byte, records the byte it receives
 * Flags idle-level and mosi-stability violations
 */

`timescale 1ns/10ps

module spi_slave_model import spi_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      sclk,
  input  logic      mosi,
  input  logic      cs_n,
  input  logic      armed,
  input  spi_byte_t reply,
  output logic      miso,
  output spi_byte_t captured,
  output int        xfer_count,
  output logic      err
);

  spi_byte_t tx_sr;
  spi_byte_t rx_sr;
  logic      out_bit;
  logic      sclk_q;
  logic      cs_q;
  logic      mosi_q;

  assign miso = (cs_n === 1'b0) ? out_bit : 1'b1;

  // Reply is loaded as cs_n falls, then one bit per falling sclk
  always @(negedge cs_n or negedge sclk) begin
    if (sclk === 1'b1) begin
      tx_sr   <= reply;
      out_bit <= reply[7];
    end else begin
      out_bit <= tx_sr[7];
      tx_sr   <= {tx_sr[6:0], 1'b0};
    end
  end

  // Pin values seen here are those of the previous clk cycle
  always @(posedge clk) begin
    if (rst) begin
      sclk_q     <= 1'b1;
      cs_q       <= 1'b1;
      mosi_q     <= 1'b0;
      rx_sr      <= '0;
      captured   <= '0;
      xfer_count <= 0;
      err        <= 1'b0;
    end else begin
      sclk_q <= sclk;
      cs_q   <= cs_n;
      mosi_q <= mosi;
      // Rising sclk, take mosi
      if (cs_n === 1'b0 && sclk_q === 1'b0 && sclk === 1'b1) begin
        rx_sr <= {rx_sr[6:0], mosi};
      end
      if (cs_q === 1'b0 && cs_n === 1'b1) begin
        captured   <= rx_sr;
        xfer_count <= xfer_count + 1;
      end
      if (cs_n === 1'b1 && sclk === 1'b0) begin
        $display("error at %0t ns: sclk low while cs_n is high", $time);
        err <= 1'b1;
      end
      if (cs_n === 1'b0 && !armed) begin
        $display("error at %0t ns: cs_n low with no transfer started", $time);
        err <= 1'b1;
      end
      if (cs_n === 1'b0 && sclk_q === 1'b1 && sclk === 1'b1 && mosi !== mosi_q) begin
        $display("error at %0t ns: mosi changed while sclk was high", $time);
        err <= 1'b1;
      end
    end
  end

endmodule

/* test/tb_spi.sv */
/*
 * Testbench for the AXI4-Lite SPI master
 * Clock, reset, AXI4-Lite tasks and typed compare tasks
 * Stimulus table of divider, transmit and reply bytes
 * Cycle-count timeout
 */

`timescale 1ns/10ps

module tb_spi import spi_pkg::*; ();

  localparam int NUM_ENTRIES = 10;
  localparam int MAX_DIV     = 5;
  localparam int CYCLE_LIMIT = (NUM_ENTRIES + 4) * (17 * MAX_DIV + 50) + 500;

  logic       clk;
  logic       rst;
  axil_addr_t awaddr;
  logic       awvalid;
  logic       awready;
  axil_data_t wdata;
  logic [3:0] wstrb;
  logic       wvalid;
  logic       wready;
  axil_resp_t bresp;
  logic       bvalid;
  logic       bready;
  axil_addr_t araddr;
  logic       arvalid;
  logic       arready;
  axil_data_t rdata;
  axil_resp_t rresp;
  logic       rvalid;
  logic       rready;
  logic       sclk;
  logic       mosi;
  logic       cs_n;
  logic       miso;

  logic       armed;
  spi_byte_t  reply;
  spi_byte_t  captured;
  int         xfer_count;
  logic       model_err;

  // Stimulus table
  spi_div_t   tbl_div[NUM_ENTRIES];
  spi_byte_t  tbl_tx[NUM_ENTRIES];
  spi_byte_t  tbl_reply[NUM_ENTRIES];

  integer      seed;
  logic [31:0] rnd;
  int          cycles;
  int          expected_xfers;
  axil_resp_t  resp;
  axil_data_t  word;

  spi_axil_top uut (.*);

  spi_slave_model device (
    .clk        (clk),
    .rst        (rst),
    .sclk       (sclk),
    .mosi       (mosi),
    .cs_n       (cs_n),
    .armed      (armed),
    .reply      (reply),
    .miso       (miso),
    .captured   (captured),
    .xfer_count (xfer_count),
    .err        (model_err)
  );

  always begin
    clk = 1'b0;
    #4;
    clk = 1'b1;
    #4;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout: the run did not finish within %0d clock cycles", CYCLE_LIMIT);
      $display("SOME TESTS FAILED");
      $fatal(1);
    end
  end

  task automatic abort_run();
    $display("SOME TESTS FAILED");
    $fatal(1);
  endtask

  always @(posedge clk) begin
    if (model_err) begin
      $display("The SPI device model saw a pin protocol violation");
      abort_run();
    end
  end

  task automatic check_byte(input spi_byte_t got, input spi_byte_t exp, input string what);
    if (got !== exp) begin
      $display("error at %0t ns: %s is %02h, expected %02h", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic check_resp(input axil_resp_t got, input axil_resp_t exp, input string what);
    if (got !== exp) begin
      $display("error at %0t ns: %s response is %0d, expected %0d", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic check_status(input axil_data_t got, input axil_data_t exp, input string what);
    if (got !== exp) begin
      $display("error at %0t ns: %s is %08h, expected %08h", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic check_level(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic check_count(input int got, input int exp, input string what);
    if (got != exp) begin
      $display("error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
      abort_run();
    end
  endtask

  function automatic axil_data_t status_word(input logic busy_bit, input logic done_bit);
    axil_data_t w;
    w = '0;
    w[STAT_BUSY_BIT] = busy_bit;
    w[STAT_DONE_BIT] = done_bit;
    return w;
  endfunction

  // Entered and left 1 ns after a rising edge
  task automatic axil_write(input axil_addr_t addr, input axil_data_t data,
                            output axil_resp_t r);
    awaddr  = addr;
    wdata   = data;
    wstrb   = 4'hF;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    @(negedge clk);
    while (!awready) @(negedge clk);
    check_level(wready, 1'b1, "wready together with awready");
    @(posedge clk);
    #1;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    bready  = 1'b1;
    @(negedge clk);
    while (!bvalid) @(negedge clk);
    r = bresp;
    @(posedge clk);
    #1;
    bready = 1'b0;
  endtask

  task automatic axil_read(input axil_addr_t addr, output axil_data_t data,
                           output axil_resp_t r);
    araddr  = addr;
    arvalid = 1'b1;
    @(negedge clk);
    while (!arready) @(negedge clk);
    @(posedge clk);
    #1;
    arvalid = 1'b0;
    rready  = 1'b1;
    @(negedge clk);
    while (!rvalid) @(negedge clk);
    data = rdata;
    r    = rresp;
    @(posedge clk);
    #1;
    rready = 1'b0;
  endtask

  task automatic write_ok(input axil_addr_t addr, input axil_data_t data);
    axil_resp_t r;
    axil_write(addr, data, r);
    check_resp(r, RESP_OKAY, "write");
  endtask

  task automatic read_ok(input axil_addr_t addr, output axil_data_t data);
    axil_resp_t r;
    axil_read(addr, data, r);
    check_resp(r, RESP_OKAY, "read");
  endtask

  // Poll the status register until done is set
  task automatic wait_done(output axil_data_t st);
    read_ok(REG_CTRL_STATUS, st);
    while (!st[STAT_DONE_BIT]) read_ok(REG_CTRL_STATUS, st);
  endtask

  task automatic load_entry(input int i, input spi_div_t d, input spi_byte_t tx,
                            input spi_byte_t rep);
    tbl_div[i]   = d;
    tbl_tx[i]    = tx;
    tbl_reply[i] = rep;
  endtask

  // Completion checks shared by the table loop and the busy test
  task automatic finish_transfer(input spi_byte_t tx, input spi_byte_t rep);
    axil_data_t st;
    wait_done(st);
    check_status(st, status_word(1'b0, 1'b1), "status at completion");
    expected_xfers++;
    check_level(cs_n, 1'b1, "cs_n after completion");
    check_level(sclk, 1'b1, "sclk after completion");
    read_ok(REG_RXDATA, st);
    check_byte(st[7:0], rep, "received byte");
    check_byte(captured, tx, "byte seen by device");
    check_count(xfer_count, expected_xfers, "transfer count");
    read_ok(REG_CTRL_STATUS, st);
    check_status(st, status_word(1'b0, 1'b0), "status after RXDATA read");
  endtask

  task automatic run_entry(input spi_div_t d, input spi_byte_t tx, input spi_byte_t rep);
    axil_data_t st;
    write_ok(REG_DIV, {24'h0, d});
    write_ok(REG_TXDATA, {24'h0, tx});
    reply = rep;
    armed = 1'b1;
    write_ok(REG_CTRL_STATUS, 32'h1);
    read_ok(REG_CTRL_STATUS, st);
    check_status(st, status_word(1'b1, 1'b0), "status right after start");
    finish_transfer(tx, rep);
    armed = 1'b0;
  endtask

  initial begin
    rst     = 1'b1;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    armed   = 1'b0;
    reply   = '0;
    seed    = 28;
    expected_xfers = 0;

    load_entry(0, 8'd1, 8'h00, 8'hFF);
    load_entry(1, 8'd1, 8'hFF, 8'h00);
    load_entry(2, 8'd5, 8'hA5, 8'h5A);
    load_entry(3, 8'd2, 8'h3C, 8'hC3);
    load_entry(4, 8'd5, 8'h81, 8'h7E);
    load_entry(5, 8'd3, 8'h96, 8'h69);
    for (int i = 6; i < NUM_ENTRIES; i++) begin
      rnd = $random(seed);
      load_entry(i, {6'd0, rnd[1:0]} + 8'd1, rnd[15:8], rnd[23:16]);
    end

    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;

    // Register readback of the low byte
    write_ok(REG_DIV, 32'h1234_5603);
    read_ok(REG_DIV, word);
    check_status(word, 32'h0000_0003, "DIV readback");
    write_ok(REG_TXDATA, 32'hFEDC_BA5C);
    read_ok(REG_TXDATA, word);
    check_status(word, 32'h0000_005C, "TXDATA readback");

    // Unaligned byte address
    axil_write(4'h2, 32'hFFFF_FFFF, resp);
    check_resp(resp, RESP_SLVERR, "unaligned write");
    axil_read(4'h2, word, resp);
    check_resp(resp, RESP_SLVERR, "unaligned read");
    check_status(word, 32'h0, "unaligned read data");

    for (int i = 0; i < NUM_ENTRIES; i++) begin
      run_entry(tbl_div[i], tbl_tx[i], tbl_reply[i]);
    end

    // Second start and a new TXDATA during a transfer change nothing
    write_ok(REG_DIV, 32'd5);
    write_ok(REG_TXDATA, 32'hC6);
    reply = 8'h39;
    armed = 1'b1;
    write_ok(REG_CTRL_STATUS, 32'h1);
    write_ok(REG_CTRL_STATUS, 32'h1);
    write_ok(REG_TXDATA, 32'h11);
    finish_transfer(8'hC6, 8'h39);
    repeat (40) @(posedge clk);
    #1;
    check_level(cs_n, 1'b1, "cs_n after ignored start");
    read_ok(REG_CTRL_STATUS, word);
    check_status(word, status_word(1'b0, 1'b0), "status after ignored start");
    check_count(xfer_count, expected_xfers, "transfer count after ignored start");
    armed = 1'b0;

    if (model_err) begin
      $display("SOME TESTS FAILED");
      $fatal(1);
    end else begin
      $display("ALL TESTS PASSED");
      $finish;
    end
  end

endmodule

/* all.f */
common/spi_pkg.sv
spi/spi_engine.sv
spi/spi_regs.sv
verilog/spi_axil_top.sv
test/spi_slave_model.sv
test/tb_spi.sv

/* run.sh */
#!/bin/sh
# Build and run the SPI master testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps \
  --top-module tb_spi -Mdir obj_dir -o sim_tb_spi -f all.f > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_tb_spi > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "ALL TESTS PASSED" sim.log; then
  exit 0
fi
echo "Pass line not found in sim.log"
exit 1
